// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

  // instruction field widths
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // register-register major opcode
  localparam opcode_t opcode_op = 7'b0110011;

  // funct7 that selects the M extension inside OP
  localparam funct7_t funct7_muldiv = 7'b0000001;

  // RV32M multiply funct3 codes
  // mul returns the low word, the others the high word
  localparam funct3_t f3_mul    = 3'b000;
  localparam funct3_t f3_mulh   = 3'b001;
  localparam funct3_t f3_mulhsu = 3'b010;
  localparam funct3_t f3_mulhu  = 3'b011;

endpackage

// ==== mul_uarch_pkg.sv ====
package mul_uarch_pkg;

  // data word and full 64-bit product
  typedef logic [31:0] word_t;
  typedef logic [63:0] product_t;

  // signedness of operands a and b
  typedef enum logic [1:0] {
    uu = 2'b00,
    ss = 2'b01,
    su = 2'b10
  } mul_sign_e;

  // shift-add multiplier FSM
  typedef enum logic [1:0] {
    idle   = 2'b00,
    run    = 2'b01,
    finish = 2'b10
  } mul_state_e;

  // one multiplier bit per run cycle
  localparam int mul_cycles = 32;

endpackage

// ==== shift_add_multiplier.sv ====
`timescale 1ns/1ps

module shift_add_multiplier (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  mul_uarch_pkg::mul_sign_e  sign,
  input  mul_uarch_pkg::word_t      a,
  input  mul_uarch_pkg::word_t      b,
  input  logic                      hold,
  output logic                      busy,
  output logic                      done,
  output mul_uarch_pkg::product_t   p
);

  localparam int cnt_w = $clog2(mul_uarch_pkg::mul_cycles);

  mul_uarch_pkg::mul_state_e state;
  logic [cnt_w-1:0]          count;
  logic                      last;

  // magnitude of a and the running {high, multiplier} register
  mul_uarch_pkg::word_t      mcand;
  mul_uarch_pkg::product_t   acc;
  logic                      negate;

  logic                      a_neg;
  logic                      b_neg;
  mul_uarch_pkg::word_t      mag_a;
  mul_uarch_pkg::word_t      mag_b;
  logic [32:0]               sum;
  mul_uarch_pkg::product_t   step;

  // only signed operands with the top bit set are negative
  always_comb begin
    a_neg = (sign != mul_uarch_pkg::uu) && a[31];
    b_neg = (sign == mul_uarch_pkg::ss) && b[31];
    mag_a = a_neg ? -a : a;
    mag_b = b_neg ? -b : b;
  end

  // add the multiplicand when the low bit is set, then shift right with carry
  always_comb begin
    sum  = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mcand} : 33'd0);
    step = {sum, acc[31:1]};
  end

  assign last = (count == cnt_w'(mul_uarch_pkg::mul_cycles - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mul_uarch_pkg::idle;
      count <= '0;
    end else begin
      case (state)
        mul_uarch_pkg::idle: begin
          if (start) begin
            state <= mul_uarch_pkg::run;
            count <= '0;
          end
        end
        mul_uarch_pkg::run: begin
          count <= count + 1'b1;
          if (last) begin
            state <= mul_uarch_pkg::finish;
          end
        end
        mul_uarch_pkg::finish: begin
          // stay here until the result has somewhere to go
          if (!hold) begin
            state <= mul_uarch_pkg::idle;
          end
        end
        default: state <= mul_uarch_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == mul_uarch_pkg::idle && start) begin
      mcand  <= mag_a;
      acc    <= {32'd0, mag_b};
      negate <= a_neg ^ b_neg;
    end else if (state == mul_uarch_pkg::run) begin
      // sign fixup folded into the last step
      if (last) begin
        acc <= negate ? -step : step;
      end else begin
        acc <= step;
      end
    end
  end

  assign busy = (state != mul_uarch_pkg::idle);
  assign done = (state == mul_uarch_pkg::finish);
  assign p    = acc;

  // the station starts a new operation only on an idle multiplier
  a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

  // done follows start after all run cycles plus the finish cycle
  a_done_latency: assert property (@(posedge clk) disable iff (rst)
    start |-> ##(mul_uarch_pkg::mul_cycles + 1) done);

endmodule

// ==== mul_rs.sv ====
`timescale 1ns/1ps

module mul_rs #(
  parameter int rs_depth  = 2,
  parameter int rob_idx_w = 3,
  parameter int cdb_size  = 2
) (
  input  logic                     clk,
  input  logic                     rst,

  // issue handshake and instruction fields
  input  logic                     issue_valid,
  output logic                     issue_ready,
  input  rv_isa_pkg::opcode_t      opcode,
  input  rv_isa_pkg::funct3_t      funct3,
  input  rv_isa_pkg::funct7_t      funct7,
  input  logic [rob_idx_w-1:0]     target_rob,

  // rs1 sources from regfile and ROB
  input  logic                     rs1_regfile_ready,
  input  mul_uarch_pkg::word_t     rs1_regfile_v,
  input  logic [rob_idx_w-1:0]     rs1_regfile_rob,
  input  logic                     rs1_rob_ready,
  input  mul_uarch_pkg::word_t     rs1_rob_v,

  // rs2 sources from regfile and ROB
  input  logic                     rs2_regfile_ready,
  input  mul_uarch_pkg::word_t     rs2_regfile_v,
  input  logic [rob_idx_w-1:0]     rs2_regfile_rob,
  input  logic                     rs2_rob_ready,
  input  mul_uarch_pkg::word_t     rs2_rob_v,

  // CDB broadcasts
  input  logic                     cdb_valid [cdb_size],
  input  logic [rob_idx_w-1:0]     cdb_rob   [cdb_size],
  input  mul_uarch_pkg::word_t     cdb_data  [cdb_size],

  // handoff to the result stage
  input  logic                     result_empty,
  output logic                     capture,
  output rv_isa_pkg::funct3_t      cap_funct3,
  output logic [rob_idx_w-1:0]     cap_rob,
  output mul_uarch_pkg::product_t  p
);

  localparam int entries = 2 ** rs_depth;

  typedef logic [rob_idx_w-1:0] rob_tag_t;
  typedef logic [rs_depth-1:0]  slot_t;

  // station entries
  logic                 occ     [entries];
  rv_isa_pkg::funct3_t  f3_q    [entries];
  logic                 rs1_rdy [entries];
  logic                 rs2_rdy [entries];
  mul_uarch_pkg::word_t rs1_val [entries];
  mul_uarch_pkg::word_t rs2_val [entries];
  rob_tag_t             rs1_tag [entries];
  rob_tag_t             rs2_tag [entries];
  rob_tag_t             tgt_q   [entries];

  // entry currently in the multiplier
  slot_t                exec_idx;

  logic                 m_type;
  logic                 accept;
  logic                 free_found;
  slot_t                free_idx;
  logic                 sel_found;
  slot_t                sel_idx;
  logic [32:0]          rs1_src;
  logic [32:0]          rs2_src;
  logic [32:0]          rs1_snoop [entries];
  logic [32:0]          rs2_snoop [entries];

  logic                      mul_start;
  logic                      mul_hold;
  logic                      mul_busy;
  logic                      mul_done;
  mul_uarch_pkg::mul_sign_e  mul_sign;
  mul_uarch_pkg::word_t      mul_a;
  mul_uarch_pkg::word_t      mul_b;

  // {hit, data} from a valid lane carrying this tag
  function automatic logic [32:0] cdb_lookup(input rob_tag_t tag);
    logic [32:0] r;
    r = '0;
    for (int j = 0; j < cdb_size; j++) begin
      if (cdb_valid[j] && cdb_rob[j] == tag) begin
        r = {1'b1, cdb_data[j]};
      end
    end
    return r;
  endfunction

  // regfile first, then ROB, then a same-cycle broadcast
  function automatic logic [32:0] resolve(input logic rf_rdy,
                                          input mul_uarch_pkg::word_t rf_v,
                                          input logic rob_rdy,
                                          input mul_uarch_pkg::word_t rob_v,
                                          input rob_tag_t tag);
    logic [32:0] r;
    if (rf_rdy) begin
      r = {1'b1, rf_v};
    end else if (rob_rdy) begin
      r = {1'b1, rob_v};
    end else begin
      r = cdb_lookup(tag);
    end
    return r;
  endfunction

  assign m_type = (opcode == rv_isa_pkg::opcode_op) && (funct7 == rv_isa_pkg::funct7_muldiv);

  // lowest free slot and lowest ready slot
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    sel_found  = 1'b0;
    sel_idx    = '0;
    for (int i = entries - 1; i >= 0; i--) begin
      if (!occ[i]) begin
        free_found = 1'b1;
        free_idx   = slot_t'(i);
      end
      if (occ[i] && rs1_rdy[i] && rs2_rdy[i]) begin
        sel_found = 1'b1;
        sel_idx   = slot_t'(i);
      end
    end
  end

  assign issue_ready = free_found;
  assign accept      = issue_valid && issue_ready && m_type;

  always_comb begin
    rs1_src = resolve(rs1_regfile_ready, rs1_regfile_v, rs1_rob_ready, rs1_rob_v,
                      rs1_regfile_rob);
    rs2_src = resolve(rs2_regfile_ready, rs2_regfile_v, rs2_rob_ready, rs2_rob_v,
                      rs2_regfile_rob);
    for (int i = 0; i < entries; i++) begin
      rs1_snoop[i] = cdb_lookup(rs1_tag[i]);
      rs2_snoop[i] = cdb_lookup(rs2_tag[i]);
    end
  end

  // funct3 to operand signedness, mul and mulhu both unsigned
  always_comb begin
    case (f3_q[sel_idx])
      rv_isa_pkg::f3_mulh:   mul_sign = mul_uarch_pkg::ss;
      rv_isa_pkg::f3_mulhsu: mul_sign = mul_uarch_pkg::su;
      default:               mul_sign = mul_uarch_pkg::uu;
    endcase
  end

  assign mul_start = sel_found && !mul_busy;
  assign mul_a     = rs1_val[sel_idx];
  assign mul_b     = rs2_val[sel_idx];
  assign mul_hold  = !result_empty;

  assign capture    = mul_done && result_empty;
  assign cap_funct3 = f3_q[exec_idx];
  assign cap_rob    = tgt_q[exec_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < entries; i++) begin
        occ[i] <= 1'b0;
      end
      exec_idx <= '0;
    end else begin
      if (mul_start) begin
        exec_idx <= sel_idx;
      end
      // executing entry leaves when its product is handed off
      if (capture) begin
        occ[exec_idx] <= 1'b0;
      end
      if (accept) begin
        occ[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // waiting operands wake up on a matching broadcast
    for (int i = 0; i < entries; i++) begin
      if (!rs1_rdy[i] && rs1_snoop[i][32]) begin
        rs1_rdy[i] <= 1'b1;
        rs1_val[i] <= rs1_snoop[i][31:0];
      end
      if (!rs2_rdy[i] && rs2_snoop[i][32]) begin
        rs2_rdy[i] <= 1'b1;
        rs2_val[i] <= rs2_snoop[i][31:0];
      end
    end
    if (accept) begin
      f3_q[free_idx]    <= funct3;
      tgt_q[free_idx]   <= target_rob;
      rs1_rdy[free_idx] <= rs1_src[32];
      rs1_val[free_idx] <= rs1_src[31:0];
      rs1_tag[free_idx] <= rs1_regfile_rob;
      rs2_rdy[free_idx] <= rs2_src[32];
      rs2_val[free_idx] <= rs2_src[31:0];
      rs2_tag[free_idx] <= rs2_regfile_rob;
    end
  end

  shift_add_multiplier i_mult (
    .clk   (clk),
    .rst   (rst),
    .start (mul_start),
    .sign  (mul_sign),
    .a     (mul_a),
    .b     (mul_b),
    .hold  (mul_hold),
    .busy  (mul_busy),
    .done  (mul_done),
    .p     (p)
  );

  // issue stage sends only M-extension multiplies to this unit
  a_issue_mtype: assert property (@(posedge clk) disable iff (rst) issue_valid |-> m_type);

endmodule

// ==== mul_result_stage.sv ====
`timescale 1ns/1ps

module mul_result_stage #(
  parameter int rob_idx_w = 3
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     capture,
  input  rv_isa_pkg::funct3_t      cap_funct3,
  input  logic [rob_idx_w-1:0]     cap_rob,
  input  mul_uarch_pkg::product_t  p,
  output logic                     empty,
  output logic                     result_valid,
  output mul_uarch_pkg::word_t     result_data,
  input  logic                     result_ready,
  output logic [rob_idx_w-1:0]     result_rob
);

  logic                 full;
  mul_uarch_pkg::word_t half;

  // low word for mul, high word for mulh, mulhsu and mulhu
  always_comb begin
    if (cap_funct3 == rv_isa_pkg::f3_mul) begin
      half = p[31:0];
    end else begin
      half = p[63:32];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (capture) begin
      full <= 1'b1;
    end else if (result_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      result_data <= half;
      result_rob  <= cap_rob;
    end
  end

  assign empty        = !full;
  assign result_valid = full;

  // stalled CDB write keeps its payload
  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    result_valid && !result_ready |=>
      result_valid && $stable(result_data) && $stable(result_rob));

endmodule

// ==== mul_unit_top.sv ====
`timescale 1ns/1ps

module mul_unit_top #(
  parameter int rs_depth  = 2,
  parameter int rob_idx_w = 3,
  parameter int cdb_size  = 2
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  issue_valid,
  output logic                  issue_ready,
  input  rv_isa_pkg::opcode_t   opcode,
  input  rv_isa_pkg::funct3_t   funct3,
  input  rv_isa_pkg::funct7_t   funct7,
  input  logic [rob_idx_w-1:0]  target_rob,

  input  logic                  rs1_regfile_ready,
  input  mul_uarch_pkg::word_t  rs1_regfile_v,
  input  logic [rob_idx_w-1:0]  rs1_regfile_rob,
  input  logic                  rs1_rob_ready,
  input  mul_uarch_pkg::word_t  rs1_rob_v,

  input  logic                  rs2_regfile_ready,
  input  mul_uarch_pkg::word_t  rs2_regfile_v,
  input  logic [rob_idx_w-1:0]  rs2_regfile_rob,
  input  logic                  rs2_rob_ready,
  input  mul_uarch_pkg::word_t  rs2_rob_v,

  input  logic                  cdb_valid [cdb_size],
  input  logic [rob_idx_w-1:0]  cdb_rob   [cdb_size],
  input  mul_uarch_pkg::word_t  cdb_data  [cdb_size],

  // CDB write port
  output logic                  result_valid,
  input  logic                  result_ready,
  output mul_uarch_pkg::word_t  result_data,
  output logic [rob_idx_w-1:0]  result_rob
);

  logic                    result_empty;
  logic                    capture;
  rv_isa_pkg::funct3_t     cap_funct3;
  logic [rob_idx_w-1:0]    cap_rob;
  mul_uarch_pkg::product_t product;

  mul_rs #(
    .rs_depth  (rs_depth),
    .rob_idx_w (rob_idx_w),
    .cdb_size  (cdb_size)
  ) i_rs (
    .clk               (clk),
    .rst               (rst),
    .issue_valid       (issue_valid),
    .issue_ready       (issue_ready),
    .opcode            (opcode),
    .funct3            (funct3),
    .funct7            (funct7),
    .target_rob        (target_rob),
    .rs1_regfile_ready (rs1_regfile_ready),
    .rs1_regfile_v     (rs1_regfile_v),
    .rs1_regfile_rob   (rs1_regfile_rob),
    .rs1_rob_ready     (rs1_rob_ready),
    .rs1_rob_v         (rs1_rob_v),
    .rs2_regfile_ready (rs2_regfile_ready),
    .rs2_regfile_v     (rs2_regfile_v),
    .rs2_regfile_rob   (rs2_regfile_rob),
    .rs2_rob_ready     (rs2_rob_ready),
    .rs2_rob_v         (rs2_rob_v),
    .cdb_valid         (cdb_valid),
    .cdb_rob           (cdb_rob),
    .cdb_data          (cdb_data),
    .result_empty      (result_empty),
    .capture           (capture),
    .cap_funct3        (cap_funct3),
    .cap_rob           (cap_rob),
    .p                 (product)
  );

  mul_result_stage #(
    .rob_idx_w (rob_idx_w)
  ) i_result (
    .clk          (clk),
    .rst          (rst),
    .capture      (capture),
    .cap_funct3   (cap_funct3),
    .cap_rob      (cap_rob),
    .p            (product),
    .empty        (result_empty),
    .result_valid (result_valid),
    .result_data  (result_data),
    .result_ready (result_ready),
    .result_rob   (result_rob)
  );

endmodule

// ==== tb_mul_vectors.svh ====
// one add_row call per test with name, funct3, rs1 value, rs2 value and operand source
task automatic load_table();
  // station fills with four entries waiting on a later broadcast
  add_row("late_mul", rv_isa_pkg::f3_mul, 32'h1234_5678, 32'h9abc_def0, src_cdb_late);
  add_row("late_mulh", rv_isa_pkg::f3_mulh, 32'h8000_0000, 32'hffff_ffff, src_cdb_late);
  add_row("late_mulhsu", rv_isa_pkg::f3_mulhsu, 32'hffff_fffe, 32'h8000_0000, src_cdb_late);
  add_row("late_mulhu", rv_isa_pkg::f3_mulhu, 32'hffff_ffff, 32'hffff_ffff, src_cdb_late);
  // operands straight from the register file
  add_row("mul_zero", rv_isa_pkg::f3_mul, 32'h0000_0000, 32'hdead_beef, src_rf);
  add_row("mul_neg", rv_isa_pkg::f3_mul, 32'hffff_ffff, 32'h0000_0007, src_rf);
  add_row("mul_min", rv_isa_pkg::f3_mul, 32'h8000_0000, 32'h8000_0000, src_rf);
  add_row("mulh_min_min", rv_isa_pkg::f3_mulh, 32'h8000_0000, 32'h8000_0000, src_rf);
  add_row("mulh_min_neg1", rv_isa_pkg::f3_mulh, 32'h8000_0000, 32'hffff_ffff, src_rf);
  add_row("mulh_max_max", rv_isa_pkg::f3_mulh, 32'h7fff_ffff, 32'h7fff_ffff, src_rf);
  add_row("mulhsu_neg_max", rv_isa_pkg::f3_mulhsu, 32'hffff_ffff, 32'hffff_ffff, src_rf);
  add_row("mulhsu_min", rv_isa_pkg::f3_mulhsu, 32'h8000_0000, 32'hffff_ffff, src_rf);
  add_row("mulhsu_zero", rv_isa_pkg::f3_mulhsu, 32'h0000_0000, 32'h8000_0000, src_rf);
  add_row("mulhu_max", rv_isa_pkg::f3_mulhu, 32'hffff_ffff, 32'hffff_ffff, src_rf);
  add_row("mulhu_min", rv_isa_pkg::f3_mulhu, 32'h8000_0000, 32'h8000_0000, src_rf);
  // operands forwarded from the ROB
  add_row("rob_mul", rv_isa_pkg::f3_mul, 32'hcafe_f00d, 32'h0001_0001, src_rob);
  add_row("rob_mulh", rv_isa_pkg::f3_mulh, 32'hffff_0000, 32'h0001_2345, src_rob);
  add_row("rob_mulhu", rv_isa_pkg::f3_mulhu, 32'h0000_ffff, 32'hffff_0000, src_rob);
  // rs2 broadcast in the issue cycle itself
  add_row("now_mul", rv_isa_pkg::f3_mul, 32'h0000_0003, 32'hffff_fffd, src_cdb_now);
  add_row("now_mulh", rv_isa_pkg::f3_mulh, 32'h8765_4321, 32'h8000_0000, src_cdb_now);
  add_row("now_mulhsu", rv_isa_pkg::f3_mulhsu, 32'h8000_0000, 32'h0000_0000, src_cdb_now);
  add_row("now_mulhu", rv_isa_pkg::f3_mulhu, 32'h1234_5678, 32'h8765_4321, src_cdb_now);
  add_row("late2_mulh", rv_isa_pkg::f3_mulh, 32'hffff_ffff, 32'h8000_0000, src_cdb_late);
  add_row("late2_mul", rv_isa_pkg::f3_mul, 32'h0000_0000, 32'hffff_ffff, src_cdb_late);
endtask

// ==== tb_mul_unit.sv ====
`timescale 1ns/1ps

module tb_mul_unit;

  localparam int rs_depth  = 2;
  localparam int rob_idx_w = 3;
  localparam int cdb_size  = 2;
  localparam int n_tags    = 2 ** rob_idx_w;

  // operand source of a table row
  localparam int src_rf       = 0;
  localparam int src_rob      = 1;
  localparam int src_cdb_late = 2;
  localparam int src_cdb_now  = 3;

  logic                 clk;
  logic                 rst;
  logic                 issue_valid;
  logic                 issue_ready;
  rv_isa_pkg::opcode_t  opcode;
  rv_isa_pkg::funct3_t  funct3;
  rv_isa_pkg::funct7_t  funct7;
  logic [rob_idx_w-1:0] target_rob;
  logic                 rs1_regfile_ready;
  logic [31:0]          rs1_regfile_v;
  logic [rob_idx_w-1:0] rs1_regfile_rob;
  logic                 rs1_rob_ready;
  logic [31:0]          rs1_rob_v;
  logic                 rs2_regfile_ready;
  logic [31:0]          rs2_regfile_v;
  logic [rob_idx_w-1:0] rs2_regfile_rob;
  logic                 rs2_rob_ready;
  logic [31:0]          rs2_rob_v;
  logic                 cdb_valid [cdb_size];
  logic [rob_idx_w-1:0] cdb_rob   [cdb_size];
  logic [31:0]          cdb_data  [cdb_size];
  logic                 result_valid;
  logic                 result_ready;
  logic [31:0]          result_data;
  logic [rob_idx_w-1:0] result_rob;

  // table columns with the expected value computed at load time
  string       row_name [$];
  logic [2:0]  row_f3   [$];
  logic [31:0] row_a    [$];
  logic [31:0] row_b    [$];
  logic [31:0] row_exp  [$];
  int          row_mode [$];

  // ROB model with tags in flight and tags still waiting on a broadcast
  logic        tag_busy [n_tags];
  logic        tag_wait [n_tags];
  int          tag_row  [n_tags];
  int          bc_row   [$];
  int          bc_tag   [$];
  int          bc_due   [$];

  int          cycle;
  int          limit;
  int          next_row;
  int          next_tag;
  int          retired;
  int          lane_used;
  logic        saw_full;
  logic        stalled;
  logic [31:0] held_data;
  logic [rob_idx_w-1:0] held_rob;

  mul_unit_top #(
    .rs_depth  (rs_depth),
    .rob_idx_w (rob_idx_w),
    .cdb_size  (cdb_size)
  ) i_dut (
    .clk               (clk),
    .rst               (rst),
    .issue_valid       (issue_valid),
    .issue_ready       (issue_ready),
    .opcode            (opcode),
    .funct3            (funct3),
    .funct7            (funct7),
    .target_rob        (target_rob),
    .rs1_regfile_ready (rs1_regfile_ready),
    .rs1_regfile_v     (rs1_regfile_v),
    .rs1_regfile_rob   (rs1_regfile_rob),
    .rs1_rob_ready     (rs1_rob_ready),
    .rs1_rob_v         (rs1_rob_v),
    .rs2_regfile_ready (rs2_regfile_ready),
    .rs2_regfile_v     (rs2_regfile_v),
    .rs2_regfile_rob   (rs2_regfile_rob),
    .rs2_rob_ready     (rs2_rob_ready),
    .rs2_rob_v         (rs2_rob_v),
    .cdb_valid         (cdb_valid),
    .cdb_rob           (cdb_rob),
    .cdb_data          (cdb_data),
    .result_valid      (result_valid),
    .result_ready      (result_ready),
    .result_data       (result_data),
    .result_rob        (result_rob)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // RV32M rule takes the 64-bit product of the operands as signed or unsigned
  function automatic logic [31:0] expected_result(input logic [2:0] f3, input logic [31:0] a,
                                                   input logic [31:0] b);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] prod;
    sa = (f3 == rv_isa_pkg::f3_mulh || f3 == rv_isa_pkg::f3_mulhsu) ? {{32{a[31]}}, a}
                                                                    : {32'd0, a};
    sb = (f3 == rv_isa_pkg::f3_mulh) ? {{32{b[31]}}, b} : {32'd0, b};
    prod = sa * sb;
    return (f3 == rv_isa_pkg::f3_mul) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic add_row(input string name, input logic [2:0] f3, input logic [31:0] a,
                         input logic [31:0] b, input int mode);
    row_name.push_back(name);
    row_f3.push_back(f3);
    row_a.push_back(a);
    row_b.push_back(b);
    row_exp.push_back(expected_result(f3, a, b));
    row_mode.push_back(mode);
  endtask

  `include "tb_mul_vectors.svh"

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // producer of a waiting operand sits in the other half of the ROB
  function automatic logic [rob_idx_w-1:0] producer_tag(input int t);
    return rob_idx_w'(t ^ (n_tags / 2));
  endfunction

  function automatic int find_free_tag();
    int found;
    int idx;
    found = -1;
    for (int k = n_tags - 1; k >= 0; k--) begin
      idx = (next_tag + k) % n_tags;
      if (!tag_busy[idx]) begin
        found = idx;
      end
    end
    return found;
  endfunction

  task automatic drive_idle();
    issue_valid = 1'b0;
    for (int j = 0; j < cdb_size; j++) begin
      cdb_valid[j] = 1'b0;
    end
  endtask

  // CDB write port with stall check, random back-pressure and scoreboard
  task automatic check_result();
    int r;
    if (stalled) begin
      r = tag_row[held_rob];
      assert (result_valid && result_data == held_data && result_rob == held_rob)
      else fail_run($sformatf("FAILED %s stalled output expected %h tag %0d actual %h tag %0d",
                              row_name[r], held_data, held_rob, result_data, result_rob));
    end
    result_ready = ($urandom % 3) != 0;
    stalled      = result_valid && !result_ready;
    held_data    = result_data;
    held_rob     = result_rob;
    if (result_valid && result_ready) begin
      assert (tag_busy[result_rob])
      else fail_run($sformatf("result for tag %0d, which has no instruction in flight",
                              result_rob));
      r = tag_row[result_rob];
      assert (!tag_wait[result_rob])
      else fail_run($sformatf("result for %s came before its operand broadcast",
                              row_name[r]));
      assert (result_data == row_exp[r])
      else fail_run($sformatf("FAILED %s expected %h actual %h", row_name[r], row_exp[r],
                              result_data));
      tag_busy[result_rob] = 1'b0;
      retired++;
    end
  endtask

  task automatic send_broadcast(output int lane);
    int r;
    int t;
    lane = -1;
    if (bc_row.size() > 0 && bc_due[0] <= cycle) begin
      r = bc_row.pop_front();
      t = bc_tag.pop_front();
      void'(bc_due.pop_front());
      lane = r % cdb_size;
      cdb_valid[lane] = 1'b1;
      cdb_rob[lane]   = producer_tag(t);
      cdb_data[lane]  = row_a[r];
      tag_wait[t]     = 1'b0;
    end
  endtask

  task automatic issue_row(input int lane_busy);
    int t;
    int r;
    int lane;
    // entries waiting on an operand can never leave the station
    if (bc_row.size() >= 2 ** rs_depth) begin
      assert (!issue_ready)
      else fail_run("issue_ready stayed high with every station entry waiting on an operand");
    end
    if (!issue_ready) begin
      saw_full = 1'b1;
    end
    t = find_free_tag();
    if (issue_ready && next_row < row_name.size() && t >= 0) begin
      r = next_row;
      next_row++;
      next_tag    = (t + 1) % n_tags;
      tag_busy[t] = 1'b1;
      tag_row[t]  = r;
      issue_valid = 1'b1;
      funct3      = row_f3[r];
      target_rob  = rob_idx_w'(t);
      // stale values on every source that must lose the priority
      rs1_regfile_ready = (row_mode[r] == src_rf);
      rs1_regfile_v     = rs1_regfile_ready ? row_a[r] : ~row_a[r];
      rs1_regfile_rob   = producer_tag(t);
      rs1_rob_ready     = (row_mode[r] != src_cdb_late);
      rs1_rob_v         = (row_mode[r] == src_rf) ? ~row_a[r] : row_a[r];
      rs2_regfile_ready = (row_mode[r] == src_rf || row_mode[r] == src_cdb_late);
      rs2_regfile_v     = rs2_regfile_ready ? row_b[r] : ~row_b[r];
      rs2_regfile_rob   = producer_tag(t);
      rs2_rob_ready     = (row_mode[r] == src_rob || row_mode[r] == src_rf);
      rs2_rob_v         = (row_mode[r] == src_rf) ? ~row_b[r] : row_b[r];
      if (row_mode[r] == src_cdb_now) begin
        lane = (lane_busy == 0) ? 1 : 0;
        cdb_valid[lane] = 1'b1;
        cdb_rob[lane]   = producer_tag(t);
        cdb_data[lane]  = row_b[r];
      end
      if (row_mode[r] == src_cdb_late) begin
        tag_wait[t] = 1'b1;
        bc_row.push_back(r);
        bc_tag.push_back(t);
        bc_due.push_back(cycle + 60 + int'($urandom % 16));
      end
    end
  endtask

  initial begin
    void'($urandom(30466));
    rst               = 1'b1;
    issue_valid       = 1'b0;
    opcode            = rv_isa_pkg::opcode_op;
    funct3            = rv_isa_pkg::f3_mul;
    funct7            = rv_isa_pkg::funct7_muldiv;
    target_rob        = '0;
    rs1_regfile_ready = 1'b0;
    rs1_regfile_v     = '0;
    rs1_regfile_rob   = '0;
    rs1_rob_ready     = 1'b0;
    rs1_rob_v         = '0;
    rs2_regfile_ready = 1'b0;
    rs2_regfile_v     = '0;
    rs2_regfile_rob   = '0;
    rs2_rob_ready     = 1'b0;
    rs2_rob_v         = '0;
    result_ready      = 1'b0;
    for (int j = 0; j < cdb_size; j++) begin
      cdb_valid[j] = 1'b0;
      cdb_rob[j]   = '0;
      cdb_data[j]  = '0;
    end
    for (int t = 0; t < n_tags; t++) begin
      tag_busy[t] = 1'b0;
      tag_wait[t] = 1'b0;
      tag_row[t]  = 0;
    end
    cycle     = 0;
    next_row  = 0;
    next_tag  = 0;
    retired   = 0;
    lane_used = -1;
    saw_full  = 1'b0;
    stalled   = 1'b0;
    held_data = '0;
    held_rob  = '0;
    load_table();
    limit = (row_name.size() + 4) * 40 * 3;

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (issue_ready && !result_valid)
    else fail_run("unit is not idle after reset");

    while (retired < row_name.size()) begin
      @(negedge clk);
      cycle++;
      if (cycle > limit) begin
        fail_run($sformatf("timeout after %0d cycles with %0d of %0d results retired",
                           cycle, retired, row_name.size()));
      end
      drive_idle();
      check_result();
      send_broadcast(lane_used);
      issue_row(lane_used);
    end

    if (saw_full) begin
      $display("TB PASSED");
      $finish;
    end else begin
      fail_run("issue_ready never fell while the station was full of waiting entries");
    end
  end

endmodule

// ==== mul_unit.f ====
+incdir+.
rv_isa_pkg.sv
mul_uarch_pkg.sv
shift_add_multiplier.sv
mul_rs.sv
mul_result_stage.sv
mul_unit_top.sv
tb_mul_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_mul_unit
FILELIST  ?= mul_unit.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
